/* rvIsaPkg.sv */
package rvIsaPkg;

    localparam int xlen     = 32;  // integer register and address width
    localparam int regCount = 32;  // x0 to x31

    typedef logic [xlen-1:0] word_t;  // data or address word

    // major opcodes, instr bits 6:0
    typedef enum logic [6:0] {
        opR      = 7'b0110011,  // reg-reg alu
        opImm    = 7'b0010011,  // reg-imm alu
        opLoad   = 7'b0000011,  // lw only
        opStore  = 7'b0100011,  // sw only
        opBranch = 7'b1100011,  // beq .. bgeu
        opJal    = 7'b1101111,  // pc relative jump
        opJalr   = 7'b1100111,  // register indirect jump
        opLui    = 7'b0110111,  // upper imm to rd
        opAuipc  = 7'b0010111   // pc + upper imm
    } opcode_e;

    // branch compare kinds, instr bits 14:12
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,  // signed
        bge  = 3'b101,  // signed
        bltu = 3'b110,
        bgeu = 3'b111
    } branchF3_e;

endpackage

/* rvCtrlPkg.sv */
package rvCtrlPkg;

    // alu op class, same codes as the control unit table
    typedef enum logic [2:0] {
        aluOpR      = 3'd0,
        aluOpI      = 3'd1,
        aluOpLoad   = 3'd2,
        aluOpStore  = 3'd3,
        aluOpBranch = 3'd4,
        aluOpJump   = 3'd5,  // jal and jalr share this
        aluOpLui    = 3'd6,
        aluOpAuipc  = 3'd7
    } aluOp_e;

    typedef enum logic [3:0] {
        ctlAdd, ctlSub, ctlAnd, ctlOr, ctlXor,
        ctlSll, ctlSrl, ctlSra, ctlSlt, ctlSltu,
        ctlPassB  // lui, b operand straight out
    } aluCtrl_e;

    typedef enum logic [1:0] {
        pcPlus4  = 2'd0,
        pcTarget = 2'd1,  // pc + imm
        pcAlu    = 2'd3   // jalr, rs1 + imm
    } pcSrc_e;

    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2,  // link value
        resPcImm   = 2'd3   // auipc
    } resultSrc_e;

    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immU = 3'd3,
        immJ = 3'd4
    } immSrc_e;

endpackage

/* ControlUnit.sv */
`timescale 1ns/10ps

module ControlUnit import rvIsaPkg::*, rvCtrlPkg::*; (
    input  opcode_e    opcode,     // instr 6:0
    input  logic       branch,     // compare result from alu
    output pcSrc_e     pcSrc,
    output resultSrc_e resultSrc,
    output logic       memWrite,
    output logic       aluSrc,     // 1 = imm on alu b
    output immSrc_e    immSrc,
    output logic       regWrite,
    output aluOp_e     aluOp       // to alu decoder
);

    always_comb begin
        // defaults leave unknown opcodes without any state change
        pcSrc     = pcPlus4;
        resultSrc = resAlu;
        memWrite  = 1'b0;
        aluSrc    = 1'b0;
        immSrc    = immI;
        regWrite  = 1'b0;
        aluOp     = aluOpR;
        case (opcode)
            opR: begin
                regWrite = 1'b1;  // rs1 op rs2
            end
            opImm: begin
                aluOp    = aluOpI;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            opLoad: begin
                aluOp     = aluOpLoad;
                aluSrc    = 1'b1;    // rs1 + offset
                resultSrc = resMem;
                regWrite  = 1'b1;
            end
            opStore: begin
                aluOp    = aluOpStore;
                aluSrc   = 1'b1;
                immSrc   = immS;
                memWrite = 1'b1;     // no reg write
            end
            opBranch: begin
                aluOp  = aluOpBranch;  // rs1 vs rs2 with b from regs
                immSrc = immB;
                pcSrc  = branch ? pcTarget : pcPlus4;
            end
            opJal: begin
                aluOp     = aluOpJump;
                aluSrc    = 1'b1;
                immSrc    = immJ;
                resultSrc = resPcPlus4;  // link
                regWrite  = 1'b1;
                pcSrc     = pcTarget;
            end
            opJalr: begin
                aluOp     = aluOpJump;
                aluSrc    = 1'b1;
                immSrc    = immI;        // target is rs1 + i-imm
                resultSrc = resPcPlus4;
                regWrite  = 1'b1;
                pcSrc     = pcAlu;
            end
            opLui: begin
                aluOp    = aluOpLui;
                aluSrc   = 1'b1;
                immSrc   = immU;
                regWrite = 1'b1;
            end
            opAuipc: begin
                aluOp     = aluOpAuipc;
                aluSrc    = 1'b1;
                immSrc    = immU;
                resultSrc = resPcImm;  // taken from the target adder
                regWrite  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* AluDecoder.sv */
`timescale 1ns/10ps

module AluDecoder import rvCtrlPkg::*; (
    input  aluOp_e     aluOp,
    input  logic [2:0] funct3,
    input  logic       funct7b5,  // instr bit 30
    output aluCtrl_e   aluCtrl
);

    logic isReg;  // r-type, sub only legal here

    assign isReg = (aluOp == aluOpR);

    always_comb begin
        case (aluOp)
            aluOpR, aluOpI: begin
                case (funct3)
                    3'b000:  aluCtrl = (isReg && funct7b5) ? ctlSub : ctlAdd;
                    3'b001:  aluCtrl = ctlSll;
                    3'b010:  aluCtrl = ctlSlt;
                    3'b011:  aluCtrl = ctlSltu;
                    3'b100:  aluCtrl = ctlXor;
                    3'b101:  aluCtrl = funct7b5 ? ctlSra : ctlSrl;  // srai has bit 30 too
                    3'b110:  aluCtrl = ctlOr;
                    default: aluCtrl = ctlAnd;  // 3'b111
                endcase
            end
            aluOpBranch: aluCtrl = ctlSub;    // compare
            aluOpLui:    aluCtrl = ctlPassB;
            default:     aluCtrl = ctlAdd;    // load, store, jumps, auipc
        endcase
    end

endmodule

/* Alu.sv */
`timescale 1ns/10ps

module Alu import rvIsaPkg::*, rvCtrlPkg::*; (
    input  word_t     a,
    input  word_t     b,
    input  aluCtrl_e  aluCtrl,
    input  branchF3_e funct3,   // compare kind for branches
    output word_t     result,
    output logic      branch    // taken flag back to control unit
);

    logic [4:0] shamt;  // low bits of b only

    assign shamt = b[4:0];

    always_comb begin
        case (aluCtrl)
            ctlAdd:   result = a + b;
            ctlSub:   result = a - b;
            ctlAnd:   result = a & b;
            ctlOr:    result = a | b;
            ctlXor:   result = a ^ b;
            ctlSll:   result = a << shamt;
            ctlSrl:   result = a >> shamt;
            ctlSra:   result = word_t'($signed(a) >>> shamt);
            ctlSlt:   result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            ctlSltu:  result = {{(xlen-1){1'b0}}, a < b};
            ctlPassB: result = b;  // lui
            default:  result = a + b;
        endcase
    end

    // separate comparator, result above stays free for the subtract
    always_comb begin
        case (funct3)
            beq:     branch = (a == b);
            bne:     branch = (a != b);
            blt:     branch = ($signed(a) < $signed(b));
            bge:     branch = ($signed(a) >= $signed(b));
            bltu:    branch = (a < b);
            bgeu:    branch = (a >= b);
            default: branch = 1'b0;  // non-branch funct3 values
        endcase
    end

endmodule

/* ImmExtend.sv */
`timescale 1ns/10ps

module ImmExtend import rvIsaPkg::*, rvCtrlPkg::*; (
    input  word_t   instr,
    input  immSrc_e immSrc,
    output word_t   imm
);

    logic s;  // sign bit, always instr 31

    assign s = instr[31];

    always_comb begin
        case (immSrc)
            immS:    imm = {{20{s}}, instr[31:25], instr[11:7]};
            immB:    imm = {{19{s}}, s, instr[7], instr[30:25], instr[11:8], 1'b0};
            immU:    imm = {instr[31:12], 12'b0};
            immJ:    imm = {{11{s}}, s, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = {{20{s}}, instr[31:20]};  // immI, loads and jalr too
        endcase
    end

endmodule

/* RegFile.sv */
`timescale 1ns/10ps

module RegFile import rvIsaPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  logic [4:0] rd,
    input  logic       we,
    input  word_t      wd,
    output word_t      rd1,
    output word_t      rd2
);

    word_t regs [regCount];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin  // x0 writes dropped
            regs[rd] <= wd;
        end
    end

    assign rd1 = regs[rs1];  // async read
    assign rd2 = regs[rs2];

    // x0 stays zero across all write traffic
    x0Rd1: assert property (@(posedge clk) disable iff (!rstN) (rs1 == 5'd0) |-> (rd1 == '0));
    x0Rd2: assert property (@(posedge clk) disable iff (!rstN) (rs2 == 5'd0) |-> (rd2 == '0));

endmodule

/* RvCore.sv */
`timescale 1ns/10ps

module RvCore import rvIsaPkg::*, rvCtrlPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    output word_t instrAddr,
    input  word_t instr,
    output logic  wbCyc,
    output logic  wbStb,
    output logic  wbWe,
    output word_t wbAdr,
    output word_t wbDatW,
    input  word_t wbDatR,
    input  logic  wbAck
);

    typedef enum logic {busIdle, busActive} busState_e;

    busState_e  busState;
    word_t      pc, pcPlus4Val, pcImm, pcNext;
    word_t      imm, rd1, rd2, srcB, aluResult, result;
    opcode_e    opcode;
    pcSrc_e     pcSrc;
    resultSrc_e resultSrc;
    immSrc_e    immSrc;
    aluOp_e     aluOp;
    aluCtrl_e   aluCtrl;
    logic       memWrite, aluSrc, regWrite, branchTaken;
    logic       isMem, advance;

    assign opcode = opcode_e'(instr[6:0]);

    ControlUnit uCtrl (.opcode(opcode), .branch(branchTaken), .pcSrc(pcSrc),
        .resultSrc(resultSrc), .memWrite(memWrite), .aluSrc(aluSrc), .immSrc(immSrc),
        .regWrite(regWrite), .aluOp(aluOp));

    AluDecoder uAluDec (.aluOp(aluOp), .funct3(instr[14:12]), .funct7b5(instr[30]),
        .aluCtrl(aluCtrl));

    ImmExtend uImm (.instr(instr), .immSrc(immSrc), .imm(imm));

    RegFile uRegs (.clk(clk), .rstN(rstN), .rs1(instr[19:15]), .rs2(instr[24:20]),
        .rd(instr[11:7]), .we(regWrite && advance), .wd(result), .rd1(rd1), .rd2(rd2));

    assign srcB = aluSrc ? imm : rd2;  // operand b mux

    Alu uAlu (.a(rd1), .b(srcB), .aluCtrl(aluCtrl), .funct3(branchF3_e'(instr[14:12])),
        .result(aluResult), .branch(branchTaken));

    assign pcPlus4Val = pc + 32'd4;
    assign pcImm      = pc + imm;  // branch, jal and auipc target

    always_comb begin
        case (pcSrc)
            pcTarget: pcNext = pcImm;
            pcAlu:    pcNext = {aluResult[xlen-1:1], 1'b0};  // jalr clears bit 0
            default:  pcNext = pcPlus4Val;
        endcase
        case (resultSrc)
            resMem:     result = wbDatR;  // only sampled in the ack cycle
            resPcPlus4: result = pcPlus4Val;
            resPcImm:   result = pcImm;
            default:    result = aluResult;
        endcase
    end

    // memory ops wait for ack while others retire every cycle
    assign isMem   = (opcode == opLoad) || (opcode == opStore);
    assign advance = !isMem || ((busState == busActive) && wbAck);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc       <= '0;
            busState <= busIdle;
        end else begin
            if (advance) pc <= pcNext;  // held while bus busy
            case (busState)
                busIdle:   if (isMem) busState <= busActive;  // one idle cycle gives the gap
                busActive: if (wbAck) busState <= busIdle;
                default:   busState <= busIdle;
            endcase
        end
    end

    assign instrAddr = pc;
    assign wbCyc     = (busState == busActive);
    assign wbStb     = (busState == busActive);
    assign wbWe      = wbStb && memWrite;
    assign wbAdr     = aluResult;  // stable while pc held
    assign wbDatW    = rd2;

    // request held steady until the slave answers
    stbHold: assert property (@(posedge clk) disable iff (!rstN)
        (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr) && $stable(wbWe) && $stable(wbDatW)));

endmodule

/* tbRvCore.sv */
`timescale 1ns/10ps

module tbRvCore import rvIsaPkg::*;;

    localparam int    clkPeriod   = 4;    // ns
    localparam int    resetCycles = 4;
    localparam int    romWords    = 256;
    localparam int    progWords   = 224;  // random part before the dump and final jump
    localparam int    maxCycles   = 5;    // worst case per instruction is a mem op with 3 waits
    localparam word_t endPc       = 32'((romWords - 1) * 4);  // jal to self

    logic  clk, rstN, wbCyc, wbStb, wbWe, wbAck;
    word_t instrAddr, instr, wbAdr, wbDatW, wbDatR;

    word_t       rom [romWords];  // instruction memory
    word_t       dmem [512];      // data memory on byte address bits 10:2
    word_t       mRegs [32];      // model register file
    word_t       mPc;             // model pc
    int          seed = 32'he84c63c3;
    logic        busy;            // bus request seen with ack pending
    int unsigned waitLeft;

    RvCore UUT (.clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
        .wbDatR(wbDatR), .wbAck(wbAck));

    assign instr = rom[instrAddr[9:2]];  // same-cycle fetch

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic int unsigned rnd(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic stopWithFail();
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic failWith(input string msg);
        $display("%s", msg);
        stopWithFail();
    endtask

    task automatic reportMismatch(input string msg);
        $display("mismatch @ %0t: %s", $time, msg);
        stopWithFail();
    endtask

    task automatic checkPc(input word_t exp);
        if (instrAddr !== exp) reportMismatch($sformatf("pc %h, expected %h", instrAddr, exp));
    endtask

    task automatic checkStore(input word_t adr, input word_t dat);
        if (wbWe !== 1'b1) failWith("store request without wbWe");
        if (wbAdr !== adr || wbDatW !== dat)
            reportMismatch($sformatf("store %h <= %h, expected %h <= %h",
                wbAdr, wbDatW, adr, dat));
    endtask

    task automatic checkLoadAdr(input word_t adr);
        if (wbWe !== 1'b0) failWith("load request with wbWe high");
        if (wbAdr !== adr) reportMismatch($sformatf("load adr %h, expected %h", wbAdr, adr));
    endtask

    // immediate per rv32i encoding chosen by opcode
    function automatic word_t immOf(input word_t i);
        case (opcode_e'(i[6:0]))
            opStore:        return {{20{i[31]}}, i[31:25], i[11:7]};
            opBranch:       return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            opJal:          return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            opLui, opAuipc: return {i[31:12], 12'b0};
            default:        return {{20{i[31]}}, i[31:20]};
        endcase
    endfunction

    function automatic word_t aluRef(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;  // alt only for sub
            3'd1:    return a << b[4:0];
            3'd2:    return word_t'($signed(a) < $signed(b));
            3'd3:    return word_t'(a < b);
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // one retired instruction of the reference model
    task automatic stepModel(input word_t ins);
        word_t a, b, imm, adr, res, nxt;
        logic  wr, tk;
        a   = mRegs[ins[19:15]];
        b   = mRegs[ins[24:20]];
        imm = immOf(ins);
        adr = a + imm;
        res = '0;
        nxt = mPc + 32'd4;
        wr  = 1'b1;
        tk  = 1'b0;
        case (opcode_e'(ins[6:0]))
            opR:     res = aluRef(ins[14:12], ins[30], a, b);
            opImm:   res = aluRef(ins[14:12], ins[30] && (ins[14:12] == 3'd5), a, imm);
            opLoad:  res = dmem[adr[10:2]];
            opStore: begin
                wr = 1'b0;
                dmem[adr[10:2]] = b;
            end
            opBranch: begin
                wr = 1'b0;
                case (ins[14:12])
                    3'b000:  tk = (a == b);
                    3'b001:  tk = (a != b);
                    3'b100:  tk = ($signed(a) < $signed(b));
                    3'b101:  tk = ($signed(a) >= $signed(b));
                    3'b110:  tk = (a < b);
                    default: tk = (a >= b);
                endcase
                if (tk) nxt = mPc + imm;
            end
            opJal: begin
                res = mPc + 32'd4;  // link
                nxt = mPc + imm;
            end
            opJalr: begin
                res = mPc + 32'd4;
                nxt = adr & ~32'd1;
            end
            opLui:   res = imm;
            opAuipc: res = mPc + imm;
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) mRegs[ins[11:7]] = res;
        mPc = nxt;
    endtask

    // random instruction at rom index idx with forward-only control flow
    function automatic word_t genInstr(input int unsigned idx);
        logic [4:0]  rd, r1, r2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] i12;
        logic [19:0] u20;
        logic [20:0] off;
        int unsigned maxW;
        rd   = 5'(rnd(32));
        r1   = 5'(rnd(32));
        r2   = 5'(rnd(32));
        f3   = 3'(rnd(8));
        i12  = 12'(rnd(4096));
        u20  = 20'(rnd(32'h100000));
        maxW = (progWords - idx < 4) ? progWords - idx : 4;  // stay inside the program
        off  = 21'(4 * (1 + rnd(maxW)));                     // 4 to 16 bytes
        f7   = ((f3 == 3'd0 || f3 == 3'd5) && rnd(2) == 1) ? 7'b0100000 : 7'b0;
        case (rnd(10))
            0, 1: return {f7, r2, r1, f3, rd, opR};
            2, 3: begin
                if (f3 == 3'd1) i12 = {7'b0, i12[4:0]};                      // slli
                if (f3 == 3'd5) i12 = {1'b0, i12[10], 5'b0, i12[4:0]};       // srli, srai
                return {i12, r1, f3, rd, opImm};
            end
            4: return {12'h400 + 12'(4 * rnd(32)), 5'd0, 3'b010, rd, opLoad};
            5: begin
                i12 = 12'h400 + 12'(4 * rnd(32));  // data window
                return {i12[11:5], r2, 5'd0, 3'b010, i12[4:0], opStore};
            end
            6: begin
                f3 = 3'(rnd(6));
                if (f3 >= 3'd2) f3 = f3 + 3'd2;  // skip the two unused codes
                return {off[12], off[10:5], r2, r1, f3, off[4:1], off[11], opBranch};
            end
            7: return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
            8: return {12'(4 * (idx + 1 + rnd(maxW))), 5'd0, 3'b000, rd, opJalr};
            default: return {u20, rd, (rnd(2) == 1) ? opLui : opAuipc};
        endcase
    endfunction

    // pc check, wishbone slave and model step at each falling edge
    task automatic runCycle();
        word_t   ins, memAdr;
        opcode_e op;
        ins    = rom[mPc[9:2]];
        op     = opcode_e'(ins[6:0]);
        memAdr = mRegs[ins[19:15]] + immOf(ins);
        checkPc(mPc);
        if (wbAck && wbStb === 1'b1) failWith("strobe still high in the cycle after ack");
        wbAck = 1'b0;  // ack lasts one cycle
        if (op != opLoad && op != opStore) begin
            if (wbCyc !== 1'b0) failWith("bus cycle open during a non-memory instruction");
            stepModel(ins);
        end else if (wbCyc !== wbStb) begin
            failWith("wbCyc and wbStb differ during a memory instruction");
        end else if (wbStb) begin
            if (op == opStore) begin  // request checked in every strobe cycle
                checkStore(memAdr, mRegs[ins[24:20]]);
            end else begin
                checkLoadAdr(memAdr);
            end
            if (!busy) begin
                busy     = 1'b1;
                waitLeft = rnd(4);  // 0 to 3 wait cycles
            end
            if (waitLeft != 0) begin
                waitLeft--;
            end else begin
                if (op == opLoad) wbDatR = dmem[memAdr[10:2]];
                wbAck = 1'b1;
                busy  = 1'b0;
                stepModel(ins);
            end
        end else if (busy) begin
            failWith("strobe dropped before ack");
        end
    endtask

    initial begin
        logic [11:0] dOff;
        rstN     = 1'b0;
        wbAck    = 1'b0;
        wbDatR   = '0;
        busy     = 1'b0;
        waitLeft = 0;
        mPc      = '0;
        for (int i = 0; i < 32; i++) mRegs[i] = '0;
        for (int i = 0; i < 512; i++) dmem[i] = {16'h5a00 ^ 16'(i * 4), 16'(i * 4)};
        for (int i = 0; i < progWords; i++) rom[i] = genInstr(i);
        for (int r = 1; r < 32; r++) begin  // register dump to 0x600
            dOff = 12'(12'h600 + 4 * r);
            rom[progWords + r - 1] = {dOff[11:5], 5'(r), 5'd0, 3'b010, dOff[4:0], opStore};
        end
        rom[romWords - 1] = 32'h0000006f;  // jal x0, 0
        repeat (resetCycles) @(negedge clk);
        checkPc('0);
        if (wbCyc !== 1'b0 || wbStb !== 1'b0 || wbWe !== 1'b0)
            failWith("bus active during reset");
        rstN = 1'b1;
        while (mPc != endPc) begin
            runCycle();
            @(negedge clk);
        end
        checkPc(endPc);
        @(negedge clk);
        checkPc(endPc);  // parked on jal to self
        $display("sim passed");
        $finish;
    end

    initial begin
        #(romWords * maxCycles * clkPeriod + resetCycles * clkPeriod);
        $display("timeout, program never reached its final jump");
        stopWithFail();
    end

endmodule

/* flist.f */
rvIsaPkg.sv
rvCtrlPkg.sv
ControlUnit.sv
AluDecoder.sv
Alu.sv
ImmExtend.sv
RegFile.sv
RvCore.sv
tbRvCore.sv

/* Makefile */
VERILATOR  ?= verilator
FLIST      ?= flist.f
TB_TOP     ?= tbRvCore
RTL_TOP    ?= RvCore
RTL_SRCS   ?= rvIsaPkg.sv rvCtrlPkg.sv ControlUnit.sv AluDecoder.sv Alu.sv \
              ImmExtend.sv RegFile.sv RvCore.sv
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
